// ==== slurm16_mem_pkg.sv ====
// Slurm16 memory subsystem shared widths, request struct, state encodings and bank helper
package slurm16_mem_pkg;

	localparam int CPU_WORD_BITS  = 16;	// Width of one CPU data word
	localparam int CPU_ADDR_BITS  = 16;	// Width of a CPU byte address
	localparam int WORD_ADDR_BITS = CPU_ADDR_BITS - 1;	// Byte address with the byte bit dropped
	localparam int WR_MASK_BITS   = 2;	// One enable per byte of a word

	typedef logic [CPU_WORD_BITS - 1:0]  cpu_word_t;	// Data word as seen by the CPU and the RAMs
	typedef logic [CPU_ADDR_BITS - 1:0]  cpu_addr_t;	// Byte address, top bit picks the bank
	typedef logic [WORD_ADDR_BITS - 1:0] word_addr_t;	// Word address, top bit still picks the bank
	typedef logic [WR_MASK_BITS - 1:0]   wr_mask_t;	// Bit 1 is the high byte and bit 0 the low byte

	// One memory request as it travels from a master through the arbiter to a bank
	typedef struct packed {
		logic       valid;	// Request is present this cycle
		logic       wr;	// Write when set, read otherwise
		wr_mask_t   wr_mask;	// Byte enables, only looked at on a write
		word_addr_t addr;	// Word address of the access
		cpu_word_t  data;	// Write data, ignored on a read
	} mem_req_t;

	// Sequencer states of the CPU memory interface
	typedef enum logic [3:0] {
		cpust_halt            = 4'd0,	// Asleep, nothing is fetched
		cpust_execute         = 4'd1,	// Fetching and running plain instructions
		cpust_wait_mem_ready1 = 4'd2,	// First penalty cycle after a bank change for a fetch
		cpust_wait_mem_ready2 = 4'd3,	// Asking for the new bank and waiting for the grant
		cpust_execute_load    = 4'd4,	// Load access to data memory
		cpust_wait_mem_load1  = 4'd5,	// First penalty cycle before a load in the other bank
		cpust_wait_mem_load2  = 4'd6,	// Waiting for the grant of the load bank
		cpust_execute_store   = 4'd7,	// Store access to data memory
		cpust_wait_mem_store1 = 4'd8,	// First penalty cycle before a store in the other bank
		cpust_wait_mem_store2 = 4'd9	// Waiting for the grant of the store bank
	} cpu_state_e;

	// Which master currently holds a bank
	typedef enum logic {
		OWNER_CPU = 1'b0,	// The CPU memory interface
		OWNER_EXT = 1'b1	// The external port, a DMA or video master
	} bank_owner_e;

	// The bank bit is the top bit of the word address
	function automatic logic bank_of(input word_addr_t addr);
		return addr[WORD_ADDR_BITS - 1];
	endfunction

endpackage

// ==== slurm16_memory_bank.sv ====
// Slurm16 memory bank, a synchronous single port word RAM with byte write enables
`timescale 1ns/10ps

module slurm16_memory_bank import slurm16_mem_pkg::*; #(
	parameter int BANK_DEPTH_BITS = 8	// Number of word address bits decoded
) (
	input  logic      CLK,
	input  mem_req_t  req,	// Granted request from the arbiter
	output cpu_word_t q	// Read word, one cycle after the read is taken
);

	localparam int DEPTH = 2 ** BANK_DEPTH_BITS;	// Words in the bank

	localparam int HI_LSB = CPU_WORD_BITS / 2;	// First bit of the high byte

	cpu_word_t mem [DEPTH];	// Storage array, contents undefined after power up

	logic [BANK_DEPTH_BITS - 1:0] index;	// Row picked by the request
	logic                         do_write;	// Taken write this cycle
	logic                         do_read;	// Taken read this cycle

	assign index    = req.addr[BANK_DEPTH_BITS - 1:0];	// Upper address bits are ignored
	assign do_write = req.valid && req.wr;
	assign do_read  = req.valid && !req.wr;

	// Write port, each byte lane has its own enable
	always_ff @(posedge CLK) begin
		if (do_write) begin
			if (req.wr_mask[1])
				mem[index][CPU_WORD_BITS - 1:HI_LSB] <= req.data[CPU_WORD_BITS - 1:HI_LSB];
			if (req.wr_mask[0])
				mem[index][HI_LSB - 1:0] <= req.data[HI_LSB - 1:0];
		end
	end

	// Read port, q keeps the last word read until the next read
	always_ff @(posedge CLK) begin
		if (do_read)
			q <= mem[index];
	end

	a_mask_nonzero: assert property (@(posedge CLK)
		do_write |-> (req.wr_mask != '0));	// A write with no lanes would be lost silently

endmodule

// ==== slurm16_memory_arbiter.sv ====
// Slurm16 memory arbiter sharing each bank between the CPU and one external master
`timescale 1ns/10ps

module slurm16_memory_arbiter import slurm16_mem_pkg::*; #(
	parameter int BANK_DEPTH_BITS = 8	// Word address bits kept by each bank
) (
	input  logic      CLK,
	input  logic      RSTb,

	input  mem_req_t  cpu_req,	// Request from the CPU memory interface
	input  mem_req_t  ext_req,	// Request from the external port
	output logic      cpu_ready,	// CPU request is taken this cycle
	output logic      ext_ready,	// External request is taken this cycle
	output cpu_word_t cpu_mem_data,	// Read data back to the CPU
	output cpu_word_t ext_data,	// Read data back to the external port

	output mem_req_t  bank0_req,
	output mem_req_t  bank1_req,
	input  cpu_word_t bank0_q,
	input  cpu_word_t bank1_q
);

	bank_owner_e owner_r [2];	// Current holder of each bank
	logic [1:0]  cpu_hit;	// CPU asks for this bank
	logic [1:0]  ext_hit;	// External port asks for this bank
	mem_req_t    cpu_trim;	// CPU request with the address cut to the bank depth
	mem_req_t    ext_trim;
	mem_req_t    bank_req [2];	// Granted request per bank
	logic        cpu_sel_r;	// Bank of the last CPU access, picks the return word
	logic        ext_sel_r;

	// Decode which bank each master addresses
	always_comb begin
		for (int b = 0; b < 2; b++) begin
			cpu_hit[b] = cpu_req.valid && (bank_of(cpu_req.addr) == b[0]);
			ext_hit[b] = ext_req.valid && (bank_of(ext_req.addr) == b[0]);
		end
	end

	// Ownership moves only when the holder is idle on that bank and the other master asks
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			owner_r[0] <= OWNER_CPU;
			owner_r[1] <= OWNER_CPU;
		end else begin
			for (int b = 0; b < 2; b++) begin
				if (owner_r[b] == OWNER_CPU && !cpu_hit[b] && ext_hit[b])
					owner_r[b] <= OWNER_EXT;
				else if (owner_r[b] == OWNER_EXT && !ext_hit[b] && cpu_hit[b])
					owner_r[b] <= OWNER_CPU;
			end
		end
	end

	// Grants come straight from the request and the owner registers
	assign cpu_ready = cpu_req.valid && (owner_r[bank_of(cpu_req.addr)] == OWNER_CPU);
	assign ext_ready = ext_req.valid && (owner_r[bank_of(ext_req.addr)] == OWNER_EXT);

	// Higher word address bits alias onto the bank
	always_comb begin
		cpu_trim      = cpu_req;
		cpu_trim.addr = word_addr_t'(cpu_req.addr[BANK_DEPTH_BITS - 1:0]);
		ext_trim      = ext_req;
		ext_trim.addr = word_addr_t'(ext_req.addr[BANK_DEPTH_BITS - 1:0]);
	end

	// Route the owner's request, valid only when it really addresses the bank
	always_comb begin
		for (int b = 0; b < 2; b++) begin
			if (owner_r[b] == OWNER_CPU) begin
				bank_req[b]       = cpu_trim;
				bank_req[b].valid = cpu_hit[b];
			end else begin
				bank_req[b]       = ext_trim;
				bank_req[b].valid = ext_hit[b];
			end
		end
	end

	assign bank0_req = bank_req[0];
	assign bank1_req = bank_req[1];

	// Remember where each master's taken access went, the bank answers one cycle later
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cpu_sel_r <= 1'b0;
			ext_sel_r <= 1'b0;
		end else begin
			if (cpu_ready)
				cpu_sel_r <= bank_of(cpu_req.addr);
			if (ext_ready)
				ext_sel_r <= bank_of(ext_req.addr);
		end
	end

	assign cpu_mem_data = cpu_sel_r ? bank1_q : bank0_q;
	assign ext_data     = ext_sel_r ? bank1_q : bank0_q;

	a_ready_exclusive: assert property (@(posedge CLK) disable iff (!RSTb)
		(cpu_ready && ext_ready) |-> (bank_of(cpu_req.addr) != bank_of(ext_req.addr)));

endmodule

// ==== slurm16_cpu_memory_interface.sv ====
// Slurm16 CPU memory interface that sequences fetches, loads and stores across two banks
`timescale 1ns/10ps

module slurm16_cpu_memory_interface import slurm16_mem_pkg::*; (
	input  logic       CLK,
	input  logic       RSTb,

	input  logic       load_memory,	// Next access is a load
	input  logic       store_memory,	// Next access is a store
	input  logic       halt,	// Put the CPU to sleep
	input  logic       wake,	// Wake the CPU from halt

	input  cpu_addr_t  pc,	// Fetch address from the program counter
	input  cpu_addr_t  load_store_address,	// Data address of a load or store
	input  cpu_word_t  store_memory_data,	// Word to store
	input  wr_mask_t   store_memory_wr_mask,	// Byte enables of the store

	input  logic       memory_ready,	// Grant from the arbiter for the addressed bank
	output mem_req_t   cpu_req,	// Request towards the arbiter

	output logic       is_executing,	// Pipeline may advance this cycle
	output logic       is_fetching,	// Next cycle executes a plain fetch
	output logic       memory_is_instruction,	// Returning word comes from a fetch
	output cpu_addr_t  memory_address_prev_plus_two,	// Return address for calls
	output wr_mask_t   memory_wr_mask_delayed	// Mask one execute cycle older, for write back
);

	cpu_state_e state_r;	// Current sequencer state
	cpu_state_e state_next;	// State for the next cycle

	cpu_addr_t  addr_r;	// Byte address being issued now
	cpu_addr_t  next_addr;	// Byte address to issue next
	word_addr_t cur_word;	// Word form of the issued address
	word_addr_t next_word;	// Word form of the next address
	logic       bank_switch;	// Next access lands in the other bank

	cpu_word_t  store_data_r;	// Registered store word
	wr_mask_t   wr_mask_r;	// Registered store byte enables
	wr_mask_t   wr_mask_del_r;	// Byte enables from the executing cycle before
	logic       is_instr_r;	// Last access was an instruction fetch
	logic       is_instr_next;
	cpu_addr_t  prev_plus_two_r;	// Issued address plus two, one cycle late

	logic       exec;	// One of the three execute states
	logic       req_valid;	// Request valid for the current state
	logic       req_wr;	// Request is a write for the current state

	assign cur_word    = addr_r[CPU_ADDR_BITS - 1:1];	// Drop the byte bit
	assign next_word   = next_addr[CPU_ADDR_BITS - 1:1];
	assign bank_switch = bank_of(cur_word) != bank_of(next_word);	// Compare top address bits

	// Control registers
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_r       <= cpust_wait_mem_ready1;	// Start with the bank penalty then ask for a grant
			addr_r        <= '0;
			is_instr_r    <= 1'b0;
			wr_mask_r     <= 2'b11;
			wr_mask_del_r <= 2'b11;
		end else begin
			state_r    <= state_next;
			addr_r     <= next_addr;
			is_instr_r <= is_instr_next;
			if (exec) begin
				wr_mask_r     <= store_memory_wr_mask;	// Captured with the store request
				wr_mask_del_r <= wr_mask_r;	// Lines up with the word returning from memory
			end
		end
	end

	// Data path registers
	always_ff @(posedge CLK) begin
		if (exec)
			store_data_r <= store_memory_data;	// Word goes out in the following store state
		prev_plus_two_r <= addr_r + cpu_addr_t'(2);	// Address after the current instruction
	end

	// Sequencer where a bank change costs two cycles and a grant
	always_comb begin
		state_next    = state_r;
		is_instr_next = is_instr_r;
		case (state_r)
			cpust_halt: begin
				if (wake)
					state_next = cpust_wait_mem_ready1;	// Same start as after reset
			end
			cpust_execute: begin
				is_instr_next = 1'b1;	// Word in flight is an instruction
				if (halt)
					state_next = cpust_halt;
				else if (load_memory)
					state_next = bank_switch ? cpust_wait_mem_load1 : cpust_execute_load;
				else if (store_memory)
					state_next = bank_switch ? cpust_wait_mem_store1 : cpust_execute_store;
				else if (bank_switch)
					state_next = cpust_wait_mem_ready1;	// Fetch crosses into the other bank
			end
			cpust_wait_mem_ready1:
				state_next = cpust_wait_mem_ready2;
			cpust_wait_mem_ready2: begin
				if (memory_ready)
					state_next = cpust_execute;	// Grant came and the request is taken now
			end
			cpust_execute_load: begin
				is_instr_next = 1'b0;	// Word in flight is data
				if (!load_memory)
					state_next = bank_switch ? cpust_wait_mem_ready1 : cpust_execute;
				else if (bank_switch)
					state_next = cpust_wait_mem_load1;	// Back to back load in the other bank
			end
			cpust_wait_mem_load1:
				state_next = cpust_wait_mem_load2;
			cpust_wait_mem_load2: begin
				if (memory_ready)
					state_next = cpust_execute_load;
			end
			cpust_execute_store: begin
				is_instr_next = 1'b0;
				if (!store_memory)
					state_next = bank_switch ? cpust_wait_mem_ready1 : cpust_execute;
				else if (bank_switch)
					state_next = cpust_wait_mem_store1;
			end
			cpust_wait_mem_store1:
				state_next = cpust_wait_mem_store2;
			cpust_wait_mem_store2: begin
				if (memory_ready)
					state_next = cpust_execute_store;
			end
			default:
				state_next = cpust_halt;	// Park on an unknown encoding
		endcase
	end

	// The issued address only moves on when the pipeline advances
	always_comb begin
		next_addr = addr_r;
		if (exec) begin
			if (load_memory || store_memory)
				next_addr = load_store_address;
			else
				next_addr = pc;
		end
	end

	// Request strobes per state
	always_comb begin
		req_valid = 1'b0;
		req_wr    = 1'b0;
		case (state_r)
			cpust_execute, cpust_wait_mem_ready2,
			cpust_execute_load, cpust_wait_mem_load2:
				req_valid = 1'b1;	// Reads are held in the wait state until granted
			cpust_execute_store, cpust_wait_mem_store2: begin
				req_valid = 1'b1;
				req_wr    = 1'b1;
			end
			default: ;
		endcase
	end

	assign exec = (state_r == cpust_execute) || (state_r == cpust_execute_load) ||
		(state_r == cpust_execute_store);

	assign cpu_req.valid   = req_valid;
	assign cpu_req.wr      = req_wr;
	assign cpu_req.wr_mask = wr_mask_r;
	assign cpu_req.addr    = cur_word;
	assign cpu_req.data    = store_data_r;

	assign is_executing                 = exec;
	assign is_fetching                  = (state_next == cpust_execute);	// Looks one cycle ahead
	assign memory_is_instruction        = is_instr_r;
	assign memory_address_prev_plus_two = prev_plus_two_r;
	assign memory_wr_mask_delayed       = wr_mask_del_r;

	a_state_legal: assert property (@(posedge CLK) disable iff (!RSTb)
		state_r inside {cpust_halt, cpust_execute, cpust_wait_mem_ready1, cpust_wait_mem_ready2,
			cpust_execute_load, cpust_wait_mem_load1, cpust_wait_mem_load2,
			cpust_execute_store, cpust_wait_mem_store1, cpust_wait_mem_store2});

	a_wr_needs_valid: assert property (@(posedge CLK) disable iff (!RSTb)
		cpu_req.wr |-> cpu_req.valid);

endmodule

// ==== slurm16_memory_subsystem.sv ====
// Slurm16 memory subsystem top joining the CPU interface, the arbiter and two banks
`timescale 1ns/10ps

module slurm16_memory_subsystem import slurm16_mem_pkg::*; #(
	parameter int BANK_DEPTH_BITS = 8	// Word address bits per bank
) (
	input  logic      CLK,
	input  logic      RSTb,

	input  logic      load_memory,	// CPU controls from the core
	input  logic      store_memory,
	input  logic      halt,
	input  logic      wake,
	input  cpu_addr_t pc,
	input  cpu_addr_t load_store_address,
	input  cpu_word_t store_memory_data,
	input  wr_mask_t  store_memory_wr_mask,

	input  mem_req_t  ext_req,	// External master, held until ext_ready
	output logic      ext_ready,
	output cpu_word_t ext_data,

	output cpu_word_t cpu_mem_data,	// Fetched instruction or loaded word
	output logic      is_executing,
	output logic      is_fetching,
	output logic      memory_is_instruction,
	output cpu_addr_t memory_address_prev_plus_two,
	output wr_mask_t  memory_wr_mask_delayed
);

	mem_req_t  cpu_req;	// Interface to arbiter
	logic      cpu_ready;	// Arbiter grant to the interface
	mem_req_t  bank0_req;	// Arbiter to lower bank
	mem_req_t  bank1_req;	// Arbiter to upper bank
	cpu_word_t bank0_q;
	cpu_word_t bank1_q;

	slurm16_cpu_memory_interface cpu_if_i (
		.CLK(CLK), .RSTb(RSTb),
		.load_memory(load_memory), .store_memory(store_memory), .halt(halt), .wake(wake),
		.pc(pc), .load_store_address(load_store_address),
		.store_memory_data(store_memory_data), .store_memory_wr_mask(store_memory_wr_mask),
		.memory_ready(cpu_ready), .cpu_req(cpu_req),
		.is_executing(is_executing), .is_fetching(is_fetching),
		.memory_is_instruction(memory_is_instruction),
		.memory_address_prev_plus_two(memory_address_prev_plus_two),
		.memory_wr_mask_delayed(memory_wr_mask_delayed)
	);

	slurm16_memory_arbiter #(.BANK_DEPTH_BITS(BANK_DEPTH_BITS)) arbiter_i (
		.CLK(CLK), .RSTb(RSTb),
		.cpu_req(cpu_req), .ext_req(ext_req),
		.cpu_ready(cpu_ready), .ext_ready(ext_ready),
		.cpu_mem_data(cpu_mem_data), .ext_data(ext_data),
		.bank0_req(bank0_req), .bank1_req(bank1_req),
		.bank0_q(bank0_q), .bank1_q(bank1_q)
	);

	slurm16_memory_bank #(.BANK_DEPTH_BITS(BANK_DEPTH_BITS)) bank0_i (	// Byte addresses below 0x8000
		.CLK(CLK), .req(bank0_req), .q(bank0_q)
	);

	slurm16_memory_bank #(.BANK_DEPTH_BITS(BANK_DEPTH_BITS)) bank1_i (	// Byte addresses from 0x8000
		.CLK(CLK), .req(bank1_req), .q(bank1_q)
	);

endmodule

// ==== slurm16_memory_subsystem_tb.sv ====
// Slurm16 memory subsystem testbench driving a step table against a reference memory model
`timescale 1ns/10ps

module slurm16_memory_subsystem_tb import slurm16_mem_pkg::*; ();

	localparam int BANK_DEPTH_BITS = 8;	// Same depth as the DUT default
	localparam int CLK_PERIOD      = 20;
	localparam int GAP_LIMIT       = 50;	// Longest wait for is_executing to come back

	// One row of the stimulus table
	typedef struct packed {
		logic      ld;	// load_memory
		logic      st;	// store_memory
		logic      hlt;	// halt
		logic      wk;	// wake
		cpu_addr_t pc;
		cpu_addr_t ls;	// load_store_address
		cpu_word_t data;	// Store word
		wr_mask_t  mask;	// Store byte enables
		mem_req_t  ext;	// External port request held for the whole row
		logic      chk_read;	// Compare cpu_mem_data with the model at ls
		logic      chk_ext;	// Compare ext_data with the model at the external address
		logic      exp_low;	// is_executing must stay low for the whole row
		int        gap;	// Expected cycles without is_executing or negative to skip
		int        hold;	// Cycles the row lasts once executing
	} step_t;

	logic      CLK;
	logic      RSTb;
	logic      load_memory, store_memory, halt, wake;
	cpu_addr_t pc, load_store_address;
	cpu_word_t store_memory_data;
	wr_mask_t  store_memory_wr_mask;
	mem_req_t  ext_req;
	logic      ext_ready;
	cpu_word_t ext_data, cpu_mem_data;
	logic      is_executing, is_fetching, memory_is_instruction;
	cpu_addr_t memory_address_prev_plus_two;
	wr_mask_t  memory_wr_mask_delayed;

	step_t     steps [$];	// Stimulus table
	cpu_word_t model [2][2 ** BANK_DEPTH_BITS];	// Reference contents of both banks
	int        errors = 0;
	int        checks = 0;
	int        seed   = 52341;

	slurm16_memory_subsystem #(.BANK_DEPTH_BITS(BANK_DEPTH_BITS)) dut_i (.*);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// Mirror every write the banks take at mid cycle where the requests are stable
	always @(negedge CLK) begin
		if (RSTb) begin
			if (dut_i.bank0_req.valid && dut_i.bank0_req.wr)
				model_write(1'b0, dut_i.bank0_req);
			if (dut_i.bank1_req.valid && dut_i.bank1_req.wr)
				model_write(1'b1, dut_i.bank1_req);
		end
	end

	task automatic model_write(input logic bank, input mem_req_t req);
		logic [BANK_DEPTH_BITS - 1:0] idx;
		idx = req.addr[BANK_DEPTH_BITS - 1:0];
		if (req.wr_mask[1])
			model[bank][idx][15:8] = req.data[15:8];	// High byte lane
		if (req.wr_mask[0])
			model[bank][idx][7:0] = req.data[7:0];
	endtask

	function automatic cpu_word_t model_read(input cpu_addr_t byte_addr);
		return model[byte_addr[15]][byte_addr[BANK_DEPTH_BITS:1]];	// Bank bit then word row
	endfunction

	task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		assert (act === exp) else begin
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	function automatic mem_req_t make_ext(input logic valid, input logic wr, input wr_mask_t mask,
		input cpu_addr_t byte_addr, input cpu_word_t data);
		mem_req_t r;
		r.valid   = valid;
		r.wr      = wr;
		r.wr_mask = mask;
		r.addr    = byte_addr[15:1];	// Word address of the byte address
		r.data    = data;
		return r;
	endfunction

	task automatic add_step(input logic ld, input logic st, input logic hlt, input logic wk,
		input cpu_addr_t pc_v, input cpu_addr_t ls_v, input cpu_word_t d, input wr_mask_t m,
		input mem_req_t ext, input logic chk_read, input logic chk_ext, input logic exp_low,
		input int gap, input int hold);
		step_t s;
		s = '{ld, st, hlt, wk, pc_v, ls_v, d, m, ext, chk_read, chk_ext, exp_low, gap, hold};
		steps.push_back(s);
	endtask

	task automatic run_step(input step_t s);
		int n;
		@(posedge CLK);
		load_memory          <= s.ld;
		store_memory         <= s.st;
		halt                 <= s.hlt;
		wake                 <= s.wk;
		pc                   <= s.pc;
		load_store_address   <= s.ls;
		store_memory_data    <= s.data;
		store_memory_wr_mask <= s.mask;
		ext_req              <= s.ext;
		@(negedge CLK);	// DUT has not seen the new inputs yet
		if (s.exp_low) begin
			repeat (s.hold) begin
				@(negedge CLK);
				check_value("is_executing", 16'd0, {15'd0, is_executing});
			end
			check_value("ext_ready", {15'd0, s.ext.valid}, {15'd0, ext_ready});	// Holder keeps it
			return;
		end
		n = 0;
		@(negedge CLK);
		while (!is_executing && n < GAP_LIMIT) begin
			n++;
			@(negedge CLK);
		end
		checks++;
		assert (n < GAP_LIMIT) else begin
			$display("is_executing never came back at %0t ns", $time);
			errors++;
		end
		if (s.gap >= 0)
			check_value("is_executing gap", 16'(s.gap), 16'(n));
		repeat (s.hold) @(negedge CLK);
		if (s.chk_read) begin
			check_value("cpu_mem_data", model_read(s.ls), cpu_mem_data);
			check_value("memory_is_instruction", 16'd0, {15'd0, memory_is_instruction});
		end
		if (s.st)
			check_value("memory_wr_mask_delayed", {14'd0, s.mask}, {14'd0, memory_wr_mask_delayed});
		if (!s.ld && !s.st) begin	// Plain fetch row
			check_value("memory_is_instruction", 16'd1, {15'd0, memory_is_instruction});
			check_value("memory_address_prev_plus_two", s.pc + 16'd2,
				memory_address_prev_plus_two);
		end
		check_value("ext_ready", {15'd0, s.ext.valid}, {15'd0, ext_ready});	// CPU is elsewhere
		if (s.chk_ext)
			check_value("ext_data", model_read({s.ext.addr, 1'b0}), ext_data);
	endtask

	task automatic build_table();
		cpu_addr_t pc0, pc1, a0, a1;
		cpu_word_t d [5];
		mem_req_t  idle, ext_wr, ext_rd;
		pc0 = 16'h0100;
		pc1 = 16'h8200;
		a0  = {1'b0, 6'd0, 8'($random(seed)), 1'b0};	// Random row in bank 0
		a1  = {1'b1, 6'd0, 8'($random(seed)), 1'b0};	// Random row in bank 1
		for (int i = 0; i < 5; i++)
			d[i] = 16'($random(seed));
		idle   = '0;
		ext_wr = make_ext(1'b1, 1'b1, 2'b11, a1, d[4]);
		ext_rd = make_ext(1'b1, 1'b0, 2'b11, a1, 16'd0);
		add_step(0, 0, 0, 0, pc0, a0, 0, 2'b11, idle, 0, 0, 0, 0, 3);	// Fetch
		add_step(0, 1, 0, 0, pc0, a0, d[0], 2'b11, idle, 0, 0, 0, 0, 3);	// Full word store
		add_step(1, 0, 0, 0, pc0, a0, 0, 2'b11, idle, 1, 0, 0, 0, 3);
		add_step(0, 1, 0, 0, pc0, a0, d[1], 2'b10, idle, 0, 0, 0, 0, 3);	// High byte store
		add_step(1, 0, 0, 0, pc0, a0, 0, 2'b11, idle, 1, 0, 0, 0, 3);
		add_step(0, 1, 0, 0, pc0, a0, d[2], 2'b01, idle, 0, 0, 0, 0, 3);	// Low byte store
		add_step(1, 0, 0, 0, pc0, a0, 0, 2'b11, idle, 1, 0, 0, 0, 3);
		add_step(0, 0, 0, 0, pc0, a0, 0, 2'b11, idle, 0, 0, 0, 0, 3);
		add_step(0, 1, 0, 0, pc0, a1, d[3], 2'b11, idle, 0, 0, 0, 2, 3);	// Store into bank 1
		add_step(0, 0, 0, 0, pc0, a1, 0, 2'b11, idle, 0, 0, 0, 2, 3);
		add_step(1, 0, 0, 0, pc0, a1, 0, 2'b11, idle, 1, 0, 0, 2, 3);	// Load across banks
		add_step(0, 0, 0, 0, pc1, a1, 0, 2'b11, idle, 0, 0, 0, 0, 3);	// Fetch from bank 1
		add_step(0, 0, 0, 0, pc0, a1, 0, 2'b11, idle, 0, 0, 0, 2, 3);
		add_step(0, 0, 0, 0, pc0, a1, 0, 2'b11, ext_wr, 0, 0, 0, 0, 4);	// External write
		add_step(1, 0, 0, 0, pc0, a1, 0, 2'b11, ext_wr, 0, 0, 1, -1, 6);	// Blocked load
		add_step(1, 0, 0, 0, pc0, a1, 0, 2'b11, idle, 1, 0, 0, 1, 3);	// Grant after release
		add_step(0, 0, 0, 0, pc0, a1, 0, 2'b11, idle, 0, 0, 0, 2, 3);
		add_step(0, 0, 0, 0, pc0, a1, 0, 2'b11, ext_rd, 0, 1, 0, 0, 3);	// External read
		add_step(0, 0, 0, 0, pc0, a1, 0, 2'b11, idle, 0, 0, 0, 0, 2);
		add_step(0, 0, 1, 0, pc0, a1, 0, 2'b11, idle, 0, 0, 1, -1, 5);	// Halt
		add_step(0, 0, 0, 1, pc0, a1, 0, 2'b11, idle, 0, 0, 0, 2, 3);	// Wake
		add_step(0, 0, 0, 0, pc0, a1, 0, 2'b11, idle, 0, 0, 0, 0, 2);
	endtask

	// Watchdog sized from the table
	initial begin
		int total;
		#1;
		total = 0;
		foreach (steps[i])
			total += steps[i].hold;
		#((total + 200) * CLK_PERIOD);
		$display("Watchdog expired before the test sequence completed");
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		RSTb                 = 1'b0;
		load_memory          = 1'b0;
		store_memory         = 1'b0;
		halt                 = 1'b0;
		wake                 = 1'b0;
		pc                   = 16'h0100;
		load_store_address   = '0;
		store_memory_data    = '0;
		store_memory_wr_mask = 2'b11;
		ext_req              = '0;
		build_table();
		repeat (10) begin
			@(negedge CLK);
			check_value("is_executing", 16'd0, {15'd0, is_executing});	// Low through reset
		end
		@(posedge CLK);
		RSTb <= 1'b1;
		@(negedge CLK);
		@(negedge CLK);	// In wait_mem_ready2 with the grant
		check_value("is_executing", 16'd0, {15'd0, is_executing});
		check_value("is_fetching", 16'd1, {15'd0, is_fetching});
		@(negedge CLK);
		check_value("is_executing", 16'd1, {15'd0, is_executing});
		foreach (steps[i])
			run_step(steps[i]);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== slurm16_memory.f ====
slurm16_mem_pkg.sv
slurm16_memory_bank.sv
slurm16_memory_arbiter.sv
slurm16_cpu_memory_interface.sv
slurm16_memory_subsystem.sv
slurm16_memory_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: slurm16_memory

sources:
  - files:
      - slurm16_mem_pkg.sv
      - slurm16_memory_bank.sv
      - slurm16_memory_arbiter.sv
      - slurm16_cpu_memory_interface.sv
      - slurm16_memory_subsystem.sv
  - target: simulation
    files:
      - slurm16_memory_subsystem_tb.sv
